/* mesh_fabric.f */
+incdir+tb
common/mesh_pkg.sv
common/fabric_pkg.sv
hdl/fabric_fifo.sv
hdl/next_tile_route.sv
tile/router.sv
tile/tile_mem.sv
tile/mini_tile.sv
hdl/req_inject.sv
hdl/rsp_collect.sv
hdl/mesh_fabric_top.sv
tb/mesh_tb.sv

/* tb/mesh_tb_checks.svh */
// check counters, typed compare tasks and bounded wait loops for the mesh testbench

int check_count = 0;     // every compare
int err_count   = 0;     // every failure of any kind

// failures that are not a value mismatch
task automatic note_error(input string what);
    err_count++;
    $display("error at %0t ns: %s", $time, what);
endtask

// whole packet compare, fields shown on mismatch
task automatic compare_trans(input string name, input t_tile_trans exp,
                             input t_tile_trans got);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
        $display("       op %0d/%0d tag %h/%h addr %h/%h data %h/%h",
                 exp.opcode, got.opcode, exp.tag, got.tag,
                 exp.address, got.address, exp.data, got.data);
    end
endtask

task automatic compare_bit(input string name, input logic exp, input logic got);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("[FAIL] %0t ns %s expected %b got %b", $time, name, exp, got);
    end
endtask

// ========================================
// bounded waits, each leaves us just after an edge

// host request held valid until host_ready is seen at an edge
task automatic wait_accept(input int limit, output bit taken);
    int n;
    taken = 1'b0;
    n     = 0;
    while (!taken && n < limit) begin
        @(posedge clk);
        taken = host_ready;     // valid is already high here
        n++;
        #DRIVE_DLY;
    end
endtask

// all outstanding reads answered, otherwise name the lost tags
task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (outstanding != 0 && n < limit) begin
        @(posedge clk);
        n++;
        #DRIVE_DLY;
    end
    if (outstanding != 0) begin
        for (int t = 0; t < 256; t++) begin
            if (pending[t]) note_error($sformatf("read tag %0d never answered", t));
        end
        abort = 1'b1;
    end
endtask

/* tb/mesh_tb.sv */
// mesh testbench: clock, reset, random traffic, scratchpad model and test sequence
`timescale 1ns/1ns
module mesh_tb
import fabric_pkg::*;
();

localparam int          MESH_X       = 2;
localparam int          MESH_Y       = 2;
localparam int          MEM_WORDS    = 16;
localparam int          FIFO_DEPTH   = 2;
localparam int          CLK_PERIOD   = 40;
localparam int          DRIVE_DLY    = 2;      // after the rising edge
localparam logic [31:0] SEED         = 32'h2545_2c41;
localparam int          ACCEPT_LIMIT = 2000;   // cycles per host request
localparam int          DRAIN_LIMIT  = 5000;
localparam int          STALL_LIMIT  = 40;     // host_ready low this long means full

logic        clk;
logic        rst;
logic        host_req_valid;
t_host_req   host_req;
logic        host_ready;
logic        rsp_valid;
t_tile_trans rsp;
logic        rsp_ready;

// ========================================
// reference model state
t_data       model_mem [MESH_Y][MESH_X][MEM_WORDS];   // [row][column][word]
t_tile_trans exp_rsp [256];                           // by tag
bit          pending [256];
int          outstanding;
logic [7:0]  next_tag;
bit          abort;          // a wait timed out, skip the rest
int          rsp_mode;       // 0 ready high, 1 random, 2 held low
bit          hold_prev;
t_tile_trans prev_rsp;

`include "mesh_tb_checks.svh"

mesh_fabric_top #(
    .MESH_X     (MESH_X),
    .MESH_Y     (MESH_Y),
    .MEM_WORDS  (MEM_WORDS),
    .FIFO_DEPTH (FIFO_DEPTH)
) dut (
    .clk            (clk),
    .rst            (rst),
    .host_req_valid (host_req_valid),
    .host_req       (host_req),
    .host_ready     (host_ready),
    .rsp_valid      (rsp_valid),
    .rsp            (rsp),
    .rsp_ready      (rsp_ready)
);

always #(CLK_PERIOD / 2) clk = ~clk;

// response back-pressure
always @(posedge clk) begin
    #DRIVE_DLY;
    case (rsp_mode)
        0:       rsp_ready = 1'b1;
        1:       rsp_ready = 1'($urandom_range(0, 1));   // about half the time
        default: rsp_ready = 1'b0;
    endcase
end

// response monitor: stall hold, tag bookkeeping, payload
always @(posedge clk) begin
    if (!rst) begin
        if (hold_prev) begin
            compare_bit("rsp_valid", 1'b1, rsp_valid);
            compare_trans("rsp", prev_rsp, rsp);       // must not move while stalled
        end
        if (rsp_valid && rsp_ready) begin
            if (!pending[rsp.tag]) begin
                note_error($sformatf("response with tag %0d was not outstanding", rsp.tag));
            end else begin
                compare_trans("rsp", exp_rsp[rsp.tag], rsp);
                pending[rsp.tag] = 1'b0;
                outstanding--;
            end
        end
        hold_prev = rsp_valid && !rsp_ready;
        prev_rsp  = rsp;
    end
end

function automatic t_host_req make_req(input t_opcode op, input int x, input int y,
                                       input int word);
    t_host_req r;
    r.opcode  = op;
    r.tag     = next_tag;
    r.address = {4'(x), 4'(y), 24'(word)};   // dest tile in the top byte
    r.data    = t_data'($urandom);
    return r;
endfunction

// model update at the accepting edge
task automatic record_req(input t_host_req r);
    int x;
    int y;
    int w;
    x = int'(r.address[31:28]);
    y = int'(r.address[27:24]);
    w = int'(r.address[23:0]);
    if (r.opcode == WRITE) begin
        model_mem[y][x-1][w] = r.data;
    end else begin
        exp_rsp[r.tag].opcode  = RD_RSP;
        exp_rsp[r.tag].tag     = r.tag;
        exp_rsp[r.tag].address = {4'(MESH_X + 1), 4'(y), 24'(w)};   // drain column
        exp_rsp[r.tag].data    = model_mem[y][x-1][w];
        pending[r.tag] = 1'b1;
        outstanding++;
        next_tag++;
    end
endtask

task automatic send_req(input t_opcode op, input int x, input int y, input int word);
    t_host_req r;
    bit        taken;
    if (!abort) begin
        r              = make_req(op, x, y, word);
        host_req_valid = 1'b1;
        host_req       = r;
        wait_accept(ACCEPT_LIMIT, taken);
        if (taken) begin
            record_req(r);
        end else begin
            note_error($sformatf("host request tag %0d was not accepted in time", r.tag));
            abort = 1'b1;
        end
        host_req_valid = 1'b0;
    end
endtask

task automatic send_random(input int count);
    t_opcode op;
    for (int n = 0; n < count; n++) begin
        op = ($urandom_range(0, 1) == 1) ? READ : WRITE;
        send_req(op, $urandom_range(MESH_X, 1), $urandom_range(MESH_Y - 1, 0),
                 $urandom_range(MEM_WORDS - 1, 0));
    end
endtask

task automatic finish_test(input int num, input string name, input int errs_before);
    $display("test %0d %s: %s, %0d errors", num, name,
             (err_count == errs_before) ? "passed" : "failed", err_count - errs_before);
endtask

// reads with responses held back until the host port stops taking requests
task automatic stall_test();
    t_host_req r;
    bit        taken;
    bit        stalled;
    int        count;
    stalled  = 1'b0;
    count    = 0;
    rsp_mode = 2;
    while (!stalled && !abort && count < 200) begin
        r              = make_req(READ, $urandom_range(MESH_X, 1),
                                  $urandom_range(MESH_Y - 1, 0),
                                  $urandom_range(MEM_WORDS - 1, 0));
        host_req_valid = 1'b1;
        host_req       = r;
        wait_accept(STALL_LIMIT, taken);
        if (taken) begin
            record_req(r);
            host_req_valid = 1'b0;
            count++;
        end else begin
            stalled = 1'b1;     // request left pending on purpose
        end
    end
    if (!stalled) note_error("host_ready never dropped while responses were held");
    rsp_mode = 0;
    if (stalled) begin
        wait_accept(ACCEPT_LIMIT, taken);
        if (taken) begin
            record_req(r);
        end else begin
            note_error("held host request not accepted after rsp_ready rose");
            abort = 1'b1;
        end
        host_req_valid = 1'b0;
    end
    wait_drain(DRAIN_LIMIT);
endtask

initial begin
    int errs;
    clk            = 1'b0;
    rst            = 1'b1;
    host_req_valid = 1'b0;
    host_req       = '0;
    rsp_ready      = 1'b1;
    rsp_mode       = 0;
    outstanding    = 0;
    next_tag       = '0;
    abort          = 1'b0;
    hold_prev      = 1'b0;
    for (int t = 0; t < 256; t++) pending[t] = 1'b0;
    void'($urandom(SEED));          // one seed for the whole run

    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;

    errs = err_count;               // idle state right after reset
    @(posedge clk);
    compare_bit("rsp_valid", 1'b0, rsp_valid);
    compare_bit("host_ready", 1'b1, host_ready);
    #DRIVE_DLY;
    finish_test(1, "reset state", errs);

    errs = err_count;               // fill every word, then read each back
    for (int y = 0; y < MESH_Y; y++)
        for (int x = 1; x <= MESH_X; x++)
            for (int w = 0; w < MEM_WORDS; w++) send_req(WRITE, x, y, w);
    for (int y = 0; y < MESH_Y; y++)
        for (int x = 1; x <= MESH_X; x++)
            for (int w = 0; w < MEM_WORDS; w++) send_req(READ, x, y, w);
    if (!abort) wait_drain(DRAIN_LIMIT);
    finish_test(2, "write all then read all", errs);

    errs = err_count;
    send_random(200);
    if (!abort) wait_drain(DRAIN_LIMIT);
    finish_test(3, "random mix, rsp_ready high", errs);

    errs = err_count;
    rsp_mode = 1;
    send_random(200);
    if (!abort) wait_drain(DRAIN_LIMIT);
    rsp_mode = 0;
    finish_test(4, "random mix, random rsp_ready", errs);

    errs = err_count;
    if (!abort) stall_test();
    finish_test(5, "long response stall", errs);

    repeat (10) @(posedge clk);     // late duplicates still show up
    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
        $display("NO ERRORS");
    end else begin
        $display("ERRORS FOUND");
    end
    $finish;
end

endmodule

/* hdl/mesh_fabric_top.sv */
// mesh top: tile grid, inter-tile links, host injector and response collector
`timescale 1ns/1ns
module mesh_fabric_top
import mesh_pkg::*, fabric_pkg::*;
#(
    parameter int MESH_X     = 2,
    parameter int MESH_Y     = 2,
    parameter int MEM_WORDS  = 16,
    parameter int FIFO_DEPTH = 2
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          host_req_valid,
    input  var t_host_req host_req,
    output logic          host_ready,
    output logic          rsp_valid,
    output t_tile_trans   rsp,
    input  logic          rsp_ready
);

// eastbound link k runs from column k to k+1, westbound the other way
logic        e_valid [MESH_Y][MESH_X+1];
logic        e_ready [MESH_Y][MESH_X+1];
t_tile_trans e_req   [MESH_Y][MESH_X+1];
logic        w_valid [MESH_Y][MESH_X+1];
logic        w_ready [MESH_Y][MESH_X+1];
t_tile_trans w_req   [MESH_Y][MESH_X+1];
// southbound link j enters row j from above, northbound leaves row j upward
logic        s_valid [MESH_Y+1][MESH_X];
logic        s_ready [MESH_Y+1][MESH_X];
t_tile_trans s_req   [MESH_Y+1][MESH_X];
logic        n_valid [MESH_Y+1][MESH_X];
logic        n_ready [MESH_Y+1][MESH_X];
t_tile_trans n_req   [MESH_Y+1][MESH_X];

logic [MESH_Y-1:0] inj_valid;
logic [MESH_Y-1:0] inj_ready;
t_tile_trans       inj_req [MESH_Y];
logic [MESH_Y-1:0] col_valid;
logic [MESH_Y-1:0] col_ready;
t_tile_trans       col_req [MESH_Y];

req_inject #(.MESH_Y(MESH_Y), .FIFO_DEPTH(FIFO_DEPTH)) u_inject (
    .clk            (clk),
    .rst            (rst),
    .host_req_valid (host_req_valid),
    .host_req       (host_req),
    .row_ready      (inj_ready),
    .host_ready     (host_ready),
    .row_req_valid  (inj_valid),
    .row_req        (inj_req)
);

// ======================================
// edge hookup and idle border links
for (genvar j = 0; j < MESH_Y; j++) begin : g_edge
    assign e_valid[j][0]      = inj_valid[j];
    assign e_req[j][0]        = inj_req[j];
    assign inj_ready[j]       = e_ready[j][0];
    assign col_valid[j]       = e_valid[j][MESH_X];
    assign col_req[j]         = e_req[j][MESH_X];
    assign e_ready[j][MESH_X] = col_ready[j];
    assign w_valid[j][MESH_X] = 1'b0;   // nothing comes back from the drain
    assign w_req[j][MESH_X]   = '0;
    assign w_ready[j][0]      = 1'b0;   // never routed to
end

for (genvar i = 0; i < MESH_X; i++) begin : g_border
    assign s_valid[0][i]      = 1'b0;
    assign s_req[0][i]        = '0;
    assign s_ready[MESH_Y][i] = 1'b0;
    assign n_valid[MESH_Y][i] = 1'b0;
    assign n_req[MESH_Y][i]   = '0;
    assign n_ready[0][i]      = 1'b0;
end

// ======================================
// tile grid, column i holds tile x = i+1
for (genvar j = 0; j < MESH_Y; j++) begin : g_row
    for (genvar i = 0; i < MESH_X; i++) begin : g_col
        mini_tile #(
            .MESH_X     (MESH_X),
            .MEM_WORDS  (MEM_WORDS),
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_tile (
            .clk                 (clk),
            .rst                 (rst),
            .local_tile_id       (make_tile_id(i + 1, j)),
            .in_north_req_valid  (s_valid[j][i]),
            .in_north_req        (s_req[j][i]),
            .in_north_ready      (n_ready[j][i]),
            .out_north_ready     (s_ready[j][i]),
            .out_north_req_valid (n_valid[j][i]),
            .out_north_req       (n_req[j][i]),
            .in_east_req_valid   (w_valid[j][i+1]),
            .in_east_req         (w_req[j][i+1]),
            .in_east_ready       (e_ready[j][i+1]),
            .out_east_ready      (w_ready[j][i+1]),
            .out_east_req_valid  (e_valid[j][i+1]),
            .out_east_req        (e_req[j][i+1]),
            .in_south_req_valid  (n_valid[j+1][i]),
            .in_south_req        (n_req[j+1][i]),
            .in_south_ready      (s_ready[j+1][i]),
            .out_south_ready     (n_ready[j+1][i]),
            .out_south_req_valid (s_valid[j+1][i]),
            .out_south_req       (s_req[j+1][i]),
            .in_west_req_valid   (e_valid[j][i]),
            .in_west_req         (e_req[j][i]),
            .in_west_ready       (w_ready[j][i]),
            .out_west_ready      (e_ready[j][i]),
            .out_west_req_valid  (w_valid[j][i]),
            .out_west_req        (w_req[j][i])
        );
    end
end

rsp_collect #(.MESH_Y(MESH_Y)) u_collect (
    .clk           (clk),
    .rst           (rst),
    .row_rsp_valid (col_valid),
    .row_rsp       (col_req),
    .rsp_ready     (rsp_ready),
    .row_ready     (col_ready),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp)
);

endmodule

/* hdl/rsp_collect.sv */
// round-robin drain of the rows' east edges into one response register
`timescale 1ns/1ns
module rsp_collect
import fabric_pkg::*;
#(
    parameter int MESH_Y = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [MESH_Y-1:0] row_rsp_valid,
    input  var t_tile_trans   row_rsp [MESH_Y],
    input  logic              rsp_ready,
    output logic [MESH_Y-1:0] row_ready,
    output logic              rsp_valid,
    output t_tile_trans       rsp
);

localparam int RW = (MESH_Y > 1) ? $clog2(MESH_Y) : 1;

logic [RW-1:0] last_row;   // last row served
logic [RW-1:0] pick;
logic          found;
logic          load;       // output register free or draining

assign load = !rsp_valid || rsp_ready;

always_comb begin
    int r;
    found = 1'b0;
    pick  = last_row;
    for (int k = 1; k <= MESH_Y; k++) begin
        r = (int'(last_row) + k) % MESH_Y;
        if (!found && row_rsp_valid[r]) begin
            found = 1'b1;
            pick  = RW'(r);
        end
    end
end

assign row_ready = (load && found) ? (MESH_Y'(1) << pick) : '0;

always_ff @(posedge clk) begin
    if (rst) begin
        rsp_valid <= 1'b0;
        last_row  <= RW'(MESH_Y - 1);
    end else if (load) begin
        rsp_valid <= found;
        if (found) last_row <= pick;
    end
end

always_ff @(posedge clk) begin
    if (load && found) rsp <= row_rsp[pick];
end

// a row kept waiting holds its packet until picked
for (genvar r = 0; r < MESH_Y; r++) begin : g_chk
    a_row_hold: assert property (@(posedge clk) disable iff (rst)
        row_rsp_valid[r] && !row_ready[r] |=> row_rsp_valid[r] && $stable(row_rsp[r]));
end

endmodule

/* hdl/req_inject.sv */
// host request queue, steers each request to the west edge of its row
`timescale 1ns/1ns
module req_inject
import mesh_pkg::*, fabric_pkg::*;
#(
    parameter int MESH_Y     = 2,
    parameter int FIFO_DEPTH = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              host_req_valid,
    input  var t_host_req     host_req,
    input  logic [MESH_Y-1:0] row_ready,
    output logic              host_ready,
    output logic [MESH_Y-1:0] row_req_valid,
    output t_tile_trans       row_req [MESH_Y]
);

logic        full;
logic        empty;
t_host_req   head;
t_tile_id    dest;

fabric_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .T_DATA(t_host_req)) u_req_q (
    .clk       (clk),
    .rst       (rst),
    .push      (host_req_valid && !full),
    .push_data (host_req),
    .pop       (|(row_req_valid & row_ready)),   // taken by its row
    .full      (full),
    .empty     (empty),
    .pop_data  (head)
);

assign host_ready = !full;
assign dest       = addr_tile_id(head.address);

always_comb begin
    for (int r = 0; r < MESH_Y; r++) begin
        row_req_valid[r]   = !empty && (int'(dest.y) == r);   // only the target row
        row_req[r].opcode  = head.opcode;
        row_req[r].tag     = head.tag;
        row_req[r].address = head.address;
        row_req[r].data    = head.data;
    end
end

endmodule

/* tile/mini_tile.sv */
// compute tile: router with the scratchpad on its local port
`timescale 1ns/1ns
module mini_tile
import mesh_pkg::*, fabric_pkg::*;
#(
    parameter int MESH_X     = 2,
    parameter int MEM_WORDS  = 16,
    parameter int FIFO_DEPTH = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  t_tile_id        local_tile_id,
    // ================ north ===============
    input  logic            in_north_req_valid,
    input  var t_tile_trans in_north_req,
    input  logic            in_north_ready,
    output logic            out_north_ready,
    output logic            out_north_req_valid,
    output t_tile_trans     out_north_req,
    // ================ east ================
    input  logic            in_east_req_valid,
    input  var t_tile_trans in_east_req,
    input  logic            in_east_ready,
    output logic            out_east_ready,
    output logic            out_east_req_valid,
    output t_tile_trans     out_east_req,
    // ================ south ===============
    input  logic            in_south_req_valid,
    input  var t_tile_trans in_south_req,
    input  logic            in_south_ready,
    output logic            out_south_ready,
    output logic            out_south_req_valid,
    output t_tile_trans     out_south_req,
    // ================ west ================
    input  logic            in_west_req_valid,
    input  var t_tile_trans in_west_req,
    input  logic            in_west_ready,
    output logic            out_west_ready,
    output logic            out_west_req_valid,
    output t_tile_trans     out_west_req
);

// local port, names match the router so it binds by name
logic        in_local_req_valid;    // endpoint response into router
t_tile_trans in_local_req;
logic        in_local_ready;        // endpoint can take a request
logic        out_local_ready;
logic        out_local_req_valid;   // router delivery to endpoint
t_tile_trans out_local_req;

router #(.FIFO_DEPTH(FIFO_DEPTH)) u_router (.*);

tile_mem #(.MESH_X(MESH_X), .MEM_WORDS(MEM_WORDS)) u_mem (
    .clk           (clk),
    .rst           (rst),
    .local_tile_id (local_tile_id),
    .in_req_valid  (out_local_req_valid),
    .in_req        (out_local_req),
    .rsp_ready     (out_local_ready),
    .in_ready      (in_local_ready),
    .rsp_valid     (in_local_req_valid),
    .rsp           (in_local_req)
);

endmodule

/* tile/tile_mem.sv */
// scratchpad endpoint: silent writes, reads answered with RD_RSP packets
`timescale 1ns/1ns
module tile_mem
import mesh_pkg::*, fabric_pkg::*;
#(
    parameter int MESH_X    = 2,
    parameter int MEM_WORDS = 16
) (
    input  logic            clk,
    input  logic            rst,
    input  t_tile_id        local_tile_id,
    input  logic            in_req_valid,
    input  var t_tile_trans in_req,
    input  logic            rsp_ready,
    output logic            in_ready,
    output logic            rsp_valid,
    output t_tile_trans     rsp
);

localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

t_data            mem [MEM_WORDS];
logic [IDX_W-1:0] word;
logic             take_wr;
logic             take_rd;

assign in_ready = !rsp_valid || rsp_ready;   // a stuck response blocks intake
assign word     = in_req.address[IDX_W-1:0];
assign take_wr  = in_req_valid && in_ready && (in_req.opcode == WRITE);
assign take_rd  = in_req_valid && in_ready && (in_req.opcode == READ);

always_ff @(posedge clk) begin
    if (take_wr) mem[word] <= in_req.data;
end

always_ff @(posedge clk) begin
    if (rst) begin
        rsp_valid <= 1'b0;
    end else if (take_rd) begin
        rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
    end
end

// response heads to our own row at the drain column, so it only goes east
always_ff @(posedge clk) begin
    if (take_rd) begin
        rsp.opcode  <= RD_RSP;
        rsp.tag     <= in_req.tag;
        rsp.address <= {make_tile_id(MESH_X + 1, local_tile_id.y), 24'(word)};
        rsp.data    <= mem[word];
    end
end

endmodule

/* tile/router.sv */
// five-port router with input queues, route lookup and round-robin registered outputs
`timescale 1ns/1ns
module router
import mesh_pkg::*, fabric_pkg::*;
#(
    parameter int FIFO_DEPTH = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  t_tile_id        local_tile_id,
    // ================ north ===============
    input  logic            in_north_req_valid,
    input  var t_tile_trans in_north_req,
    input  logic            in_north_ready,     // room at the north neighbour
    output logic            out_north_ready,
    output logic            out_north_req_valid,
    output t_tile_trans     out_north_req,
    // ================ east ================
    input  logic            in_east_req_valid,
    input  var t_tile_trans in_east_req,
    input  logic            in_east_ready,
    output logic            out_east_ready,
    output logic            out_east_req_valid,
    output t_tile_trans     out_east_req,
    // ================ south ===============
    input  logic            in_south_req_valid,
    input  var t_tile_trans in_south_req,
    input  logic            in_south_ready,
    output logic            out_south_ready,
    output logic            out_south_req_valid,
    output t_tile_trans     out_south_req,
    // ================ west ================
    input  logic            in_west_req_valid,
    input  var t_tile_trans in_west_req,
    input  logic            in_west_ready,
    output logic            out_west_ready,
    output logic            out_west_req_valid,
    output t_tile_trans     out_west_req,
    // ================ local ===============
    input  logic            in_local_req_valid,
    input  var t_tile_trans in_local_req,
    input  logic            in_local_ready,
    output logic            out_local_ready,
    output logic            out_local_req_valid,
    output t_tile_trans     out_local_req
);

localparam int P = NUM_PORTS;

// all per-port arrays are indexed by t_cardinal
logic [P-1:0] in_valid;
logic [P-1:0] dn_ready;             // downstream room per output
logic [P-1:0] q_full;
logic [P-1:0] q_empty;
logic [P-1:0] q_pop;
logic [P-1:0] load;                 // output stage free or draining
logic [P-1:0] out_valid;
logic [P-1:0] gnt [P];              // per output, one bit per input
logic [2:0]   win [P];              // winning input per output
logic [2:0]   last_gnt [P];         // round-robin pointer
t_tile_trans  in_pkt [P];
t_tile_trans  q_head [P];
t_tile_trans  out_pkt [P];
t_cardinal    head_dir [P];

assign in_valid = {in_local_req_valid, in_west_req_valid, in_south_req_valid,
                   in_east_req_valid, in_north_req_valid};
assign dn_ready = {in_local_ready, in_west_ready, in_south_ready,
                   in_east_ready, in_north_ready};

assign in_pkt[NORTH] = in_north_req;
assign in_pkt[EAST]  = in_east_req;
assign in_pkt[SOUTH] = in_south_req;
assign in_pkt[WEST]  = in_west_req;
assign in_pkt[LOCAL] = in_local_req;

assign out_north_ready = !q_full[NORTH];   // ready is queue room only
assign out_east_ready  = !q_full[EAST];
assign out_south_ready = !q_full[SOUTH];
assign out_west_ready  = !q_full[WEST];
assign out_local_ready = !q_full[LOCAL];

assign out_north_req_valid = out_valid[NORTH];
assign out_east_req_valid  = out_valid[EAST];
assign out_south_req_valid = out_valid[SOUTH];
assign out_west_req_valid  = out_valid[WEST];
assign out_local_req_valid = out_valid[LOCAL];
assign out_north_req       = out_pkt[NORTH];
assign out_east_req        = out_pkt[EAST];
assign out_south_req       = out_pkt[SOUTH];
assign out_west_req        = out_pkt[WEST];
assign out_local_req       = out_pkt[LOCAL];

for (genvar i = 0; i < P; i++) begin : g_in
    fabric_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .T_DATA(t_tile_trans)) u_in_q (
        .clk       (clk),
        .rst       (rst),
        .push      (in_valid[i] && !q_full[i]),
        .push_data (in_pkt[i]),
        .pop       (q_pop[i]),
        .full      (q_full[i]),
        .empty     (q_empty[i]),
        .pop_data  (q_head[i])
    );

    next_tile_route u_route (
        .local_tile_id (local_tile_id),
        .dest_id       (addr_tile_id(q_head[i].address)),
        .next_card     (head_dir[i])
    );
end

// each head asks for exactly one output, so an input wins at most once
always_comb begin
    int idx;
    q_pop = '0;
    for (int o = 0; o < P; o++) begin
        gnt[o]  = '0;
        win[o]  = last_gnt[o];
        load[o] = !out_valid[o] || dn_ready[o];
        for (int k = 1; k <= P; k++) begin
            idx = (int'(last_gnt[o]) + k) % P;   // start just past last winner
            if (load[o] && gnt[o] == '0 && !q_empty[idx] &&
                head_dir[idx] == t_cardinal'(o)) begin
                gnt[o][idx] = 1'b1;
                win[o]      = 3'(idx);
            end
        end
        q_pop = q_pop | gnt[o];
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        out_valid <= '0;
        for (int o = 0; o < P; o++) begin
            last_gnt[o] <= 3'(P - 1);
        end
    end else begin
        for (int o = 0; o < P; o++) begin
            if (load[o]) out_valid[o] <= |gnt[o];
            if (|gnt[o]) last_gnt[o] <= win[o];
        end
    end
end

always_ff @(posedge clk) begin
    for (int o = 0; o < P; o++) begin
        if (|gnt[o]) out_pkt[o] <= q_head[win[o]];
    end
end

// side inputs only, a packet never heads back out the side it came in by
for (genvar i = 0; i < int'(LOCAL); i++) begin : g_chk
    a_no_u_turn: assert property (@(posedge clk) disable iff (rst)
        !q_empty[i] |-> head_dir[i] != t_cardinal'(i));
end

endmodule

/* hdl/next_tile_route.sv */
// dimension ordered next hop, x first then y
`timescale 1ns/1ns
module next_tile_route
import mesh_pkg::*;
(
    input  t_tile_id  local_tile_id,
    input  t_tile_id  dest_id,
    output t_cardinal next_card
);

always_comb begin
    if (dest_id.x > local_tile_id.x) begin
        next_card = EAST;           // includes the drain edge
    end else if (dest_id.x < local_tile_id.x) begin
        next_card = WEST;
    end else if (dest_id.y > local_tile_id.y) begin
        next_card = SOUTH;          // rows grow southward
    end else if (dest_id.y < local_tile_id.y) begin
        next_card = NORTH;
    end else begin
        next_card = LOCAL;          // arrived
    end
end

endmodule

/* hdl/fabric_fifo.sv */
// small synchronous circular queue with a payload type parameter
`timescale 1ns/1ns
module fabric_fifo #(
    parameter int  FIFO_DEPTH = 2,
    parameter type T_DATA     = logic [7:0]
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  T_DATA push_data,
    input  logic  pop,
    output logic  full,
    output logic  empty,
    output T_DATA pop_data
);

localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

T_DATA            mem [FIFO_DEPTH];   // payload storage
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [PTR_W:0]   count;              // occupancy

assign full     = (count == (PTR_W+1)'(FIFO_DEPTH));
assign empty    = (count == '0);
assign pop_data = mem[rd_ptr];        // head is always visible

always_ff @(posedge clk) begin
    if (rst) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
end

always_ff @(posedge clk) begin
    if (push) begin
        mem[wr_ptr] <= push_data;
    end
end

// callers must honour full / empty
a_no_overflow:  assert property (@(posedge clk) disable iff (rst) !(push && full));
a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(pop && empty));

endmodule

/* common/fabric_pkg.sv */
// fabric opcodes, link packet and host request formats
package fabric_pkg;

    typedef enum logic [1:0] {
        READ   = 2'd0,
        WRITE  = 2'd1,
        RD_RSP = 2'd2
    } t_opcode;

    typedef logic [19:0] t_data;

    // link packet
    typedef struct packed {
        t_opcode     opcode;
        logic [7:0]  tag;       // echoed back in RD_RSP
        logic [31:0] address;   // [31:24] dest tile, low bits word index
        t_data       data;
    } t_tile_trans;

    // request as seen at the host port
    typedef struct packed {
        t_opcode     opcode;
        logic [7:0]  tag;
        logic [31:0] address;
        t_data       data;
    } t_host_req;

endpackage

/* common/mesh_pkg.sv */
// mesh topology types, port count and tile coordinate helpers
package mesh_pkg;

    // port / direction index, also used to index router port arrays
    typedef enum logic [2:0] {
        NORTH = 3'd0,
        EAST  = 3'd1,
        SOUTH = 3'd2,
        WEST  = 3'd3,
        LOCAL = 3'd4
    } t_cardinal;

    // x 0 is the host edge, x MESH_X+1 the drain edge
    typedef struct packed {
        logic [3:0] x;
        logic [3:0] y;   // row, counts from 0
    } t_tile_id;

    localparam int NUM_PORTS = 5;

    function automatic t_tile_id make_tile_id(input int x, input int y);
        t_tile_id id;
        id.x = 4'(x);
        id.y = 4'(y);
        return id;
    endfunction

    // destination tile sits in the top address byte
    function automatic t_tile_id addr_tile_id(input logic [31:0] addr);
        return t_tile_id'(addr[31:24]);
    endfunction

endpackage
